// ==== logic/zx_mem_pkg.sv ====
// ==================================================
// Memory map of the 128K / +3 machines
// ==================================================

package zx_mem_pkg;

	// Machine model, latched while reset is high
	typedef enum logic [1:0] {
		MODEL_128K  = 2'd0,
		MODEL_48K   = 2'd1,
		MODEL_PLUS3 = 2'd2
	} model_t;

	// Bus and RAM address widths
	localparam int CPU_ADDR_W = 16;
	localparam int RAM_ADDR_W = 25;

	// 16 KiB banks, RAM address is bank * 16384 + offset
	localparam int BANK_OFS_W = 14;
	localparam int BANK_W     = 7;

	// ==================================================
	// Physical bank layout
	// ==================================================

	// ROM page 0 sits here, higher pages follow
	localparam int ROM_BANK_BASE = 80;

	// Banks fixed in the middle two regions
	localparam int FIXED_BANK_1 = 5;
	localparam int FIXED_BANK_2 = 2;

endpackage

// ==== logic/zx_io_pkg.sv ====
// ==================================================
// I/O ports and CPU data path
// ==================================================

package zx_io_pkg;

	// CPU data bus
	localparam int DATA_W = 8;

	// One keyboard half-row, active low
	localparam int KEY_W = 5;

	// Kempston fire and direction bits
	localparam int JOY_W = 6;

	// Kempston decodes on the low six address bits only
	localparam logic [5:0] KEMPSTON_PORT = 6'h1F;

	// Pulled-up bus when nothing drives it
	localparam logic [DATA_W-1:0] FLOAT_BYTE = 8'hFF;

endpackage

// ==== logic/io_decode.sv ====
`timescale 1ns/1ps

// ==================================================
// I/O write detect and port decode
// ==================================================

module io_decode
	import zx_mem_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [CPU_ADDR_W-1:0] addr,
	input  logic                  iorq_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic                  page_lock,
	input  logic                  plus3,
	output logic                  page_wr,
	output logic                  plus3_wr,
	output logic                  ula_wr
);

	logic io_wr;
	logic io_wr_q;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_fe;

	// IORQ together with M1 is an interrupt acknowledge
	assign io_wr = ~iorq_n & ~wr_n & m1_n;

	// Partial decode as on the real boards
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~plus3) & ~page_lock;
	assign sel_1ffd = ~addr[15] & ~addr[14] & ~addr[13] & addr[12] & ~addr[1]
		& plus3 & ~page_lock;
	assign sel_fe   = ~addr[0] | sel_7ffd;

	// One pulse per write, however long the strobes stay low
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			page_wr  <= 1'b0;
			plus3_wr <= 1'b0;
			ula_wr   <= 1'b0;
		end else begin
			io_wr_q  <= io_wr;
			page_wr  <= io_wr & ~io_wr_q & sel_7ffd;
			plus3_wr <= io_wr & ~io_wr_q & sel_1ffd;
			ula_wr   <= io_wr & ~io_wr_q & sel_fe;
		end
	end

	// 1FFD only exists on a +3
	assert property (@(posedge clk_sys) disable iff (reset) plus3_wr |-> plus3)
		else $error("plus3_wr pulsed while the model is not +3");

endmodule

// ==== logic/paging_regs.sv ====
`timescale 1ns/1ps

// ==================================================
// Model latch and the 7FFD / 1FFD paging registers
// ==================================================

module paging_regs
	import zx_mem_pkg::*;
	import zx_io_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  model_t            model,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              page_wr,
	input  logic              plus3_wr,
	output logic              page_lock,
	output logic              plus3,
	output logic              screen_page,
	output logic              special,
	output logic [1:0]        special_map,
	output logic [2:0]        ram_page,
	output logic [3:0]        rom_page
);

	model_t            model_q;
	logic [DATA_W-1:0] reg_7ffd;
	logic [DATA_W-1:0] reg_1ffd;

	// Model is sampled for the whole reset and frozen after it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= model;
			reg_7ffd <= '0;
			reg_1ffd <= '0;
		end else begin
			if (page_wr)
				reg_7ffd <= cpu_dout;
			if (plus3_wr)
				reg_1ffd <= cpu_dout;
		end
	end

	assign plus3     = (model_q == MODEL_PLUS3);
	// 48K has no paging at all, bit 5 locks until next reset
	assign page_lock = (model_q == MODEL_48K) | reg_7ffd[5];

	assign ram_page    = reg_7ffd[2:0];
	assign screen_page = reg_7ffd[3];
	assign special     = reg_1ffd[0];
	assign special_map = reg_1ffd[2:1];

	// +3 has four ROMs at pages 8..11, the others two at 6..7
	always_comb begin
		if (plus3)
			rom_page = {2'b10, reg_1ffd[2], reg_7ffd[4]};
		else
			rom_page = {3'b011, reg_7ffd[4] | (model_q == MODEL_48K)};
	end

	// Once locked, 7FFD holds its value
	assert property (@(posedge clk_sys) disable iff (reset) $past(page_lock) |-> $stable(reg_7ffd))
		else $error("7FFD changed while locked");

endmodule

// ==== logic/mem_map.sv ====
`timescale 1ns/1ps

// ==================================================
// CPU address to physical RAM address
// ==================================================

module mem_map
	import zx_mem_pkg::*;
(
	input  logic [CPU_ADDR_W-1:0] addr,
	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [2:0]            ram_page,
	input  logic [3:0]            rom_page,
	input  logic                  special,
	input  logic [1:0]            special_map,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we
);

	logic [1:0]        region;
	logic [BANK_W-1:0] bank;
	logic              rom_sel;

	assign region  = addr[CPU_ADDR_W-1:CPU_ADDR_W-2];
	assign rom_sel = ~special & (region == 2'd0);

	always_comb begin
		if (!special) begin
			case (region)
				2'd0:    bank = BANK_W'(ROM_BANK_BASE) + BANK_W'(rom_page);
				2'd1:    bank = BANK_W'(FIXED_BANK_1);
				2'd2:    bank = BANK_W'(FIXED_BANK_2);
				default: bank = BANK_W'(ram_page);
			endcase
		end else begin
			// All-RAM maps of the +3
			case (special_map)
				2'd0:    bank = BANK_W'(region);
				2'd1:    bank = BANK_W'(region) + BANK_W'(4);
				2'd2:    bank = (region == 2'd3) ? BANK_W'(3) : BANK_W'(region) + BANK_W'(4);
				default: begin
					case (region)
						2'd0:    bank = BANK_W'(4);
						2'd1:    bank = BANK_W'(7);
						2'd2:    bank = BANK_W'(6);
						default: bank = BANK_W'(3);
					endcase
				end
			endcase
		end
	end

	assign ram_addr = RAM_ADDR_W'({bank, addr[BANK_OFS_W-1:0]});
	assign ram_rd   = ~mreq_n & ~rd_n;
	// ROM region drops writes
	assign ram_we   = ~mreq_n & ~wr_n & ~rom_sel;

	always_comb begin
		assert (!ram_we || (ram_addr[RAM_ADDR_W-1:BANK_OFS_W] < ROM_BANK_BASE))
			else $error("RAM write strobe on a ROM bank");
	end

endmodule

// ==== logic/ula_port.sv ====
`timescale 1ns/1ps

// ULA output latch, port FE
module ula_port
	import zx_io_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              ula_wr,
	output logic [2:0]        border_color,
	output logic              ear_out,
	output logic              mic_out
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (ula_wr) begin
			border_color <= cpu_dout[2:0];
			// Bit 4 speaker, bit 3 tape out
			ear_out      <= cpu_dout[4];
			mic_out      <= cpu_dout[3];
		end
	end

endmodule

// ==== logic/bus_read_mux.sv ====
`timescale 1ns/1ps

// ==================================================
// Read data returned to the CPU
// ==================================================

module bus_read_mux
	import zx_mem_pkg::*;
	import zx_io_pkg::*;
(
	input  logic [CPU_ADDR_W-1:0] addr,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  m1_n,
	input  logic [DATA_W-1:0]     ram_dout,
	input  logic [KEY_W-1:0]      key_data,
	input  logic [JOY_W-1:0]      joystick,
	input  logic                  ear_in,
	output logic [DATA_W-1:0]     cpu_din
);

	always_comb begin
		if (!mreq_n)
			cpu_din = ram_dout;
		// Interrupt acknowledge or no read in progress
		else if ((!m1_n && !iorq_n) || rd_n)
			cpu_din = FLOAT_BYTE;
		else if (addr[5:0] == KEMPSTON_PORT)
			cpu_din = DATA_W'(joystick);
		// Keyboard row with EAR in bit 6
		else if (!addr[0])
			cpu_din = {1'b1, ear_in, 1'b1, key_data};
		else
			cpu_din = FLOAT_BYTE;
	end

endmodule

// ==== logic/spectrum_mem_io.sv ====
`timescale 1ns/1ps

// ==================================================
// Paging and I/O port block of the 128K / +3
// ==================================================

module spectrum_mem_io
	import zx_mem_pkg::*;
	import zx_io_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  model_t                model,
	input  logic [CPU_ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0]     cpu_dout,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic [DATA_W-1:0]     ram_dout,
	input  logic [KEY_W-1:0]      key_data,
	input  logic [JOY_W-1:0]      joystick,
	input  logic                  ear_in,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic [DATA_W-1:0]     cpu_din,
	output logic                  screen_page,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out
);

	logic       page_wr;
	logic       plus3_wr;
	logic       ula_wr;
	logic       page_lock;
	logic       plus3;
	logic       special;
	logic [1:0] special_map;
	logic [2:0] ram_page;
	logic [3:0] rom_page;

	io_decode u_io_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.iorq_n   (iorq_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.page_lock(page_lock),
		.plus3    (plus3),
		.page_wr  (page_wr),
		.plus3_wr (plus3_wr),
		.ula_wr   (ula_wr)
	);

	paging_regs u_paging_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.model      (model),
		.cpu_dout   (cpu_dout),
		.page_wr    (page_wr),
		.plus3_wr   (plus3_wr),
		.page_lock  (page_lock),
		.plus3      (plus3),
		.screen_page(screen_page),
		.special    (special),
		.special_map(special_map),
		.ram_page   (ram_page),
		.rom_page   (rom_page)
	);

	mem_map u_mem_map (
		.addr       (addr),
		.mreq_n     (mreq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.ram_page   (ram_page),
		.rom_page   (rom_page),
		.special    (special),
		.special_map(special_map),
		.ram_addr   (ram_addr),
		.ram_rd     (ram_rd),
		.ram_we     (ram_we)
	);

	ula_port u_ula_port (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_dout    (cpu_dout),
		.ula_wr      (ula_wr),
		.border_color(border_color),
		.ear_out     (ear_out),
		.mic_out     (mic_out)
	);

	bus_read_mux u_bus_read_mux (
		.addr    (addr),
		.mreq_n  (mreq_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.m1_n    (m1_n),
		.ram_dout(ram_dout),
		.key_data(key_data),
		.joystick(joystick),
		.ear_in  (ear_in),
		.cpu_din (cpu_din)
	);

endmodule

// ==== bench/tb_spectrum_mem_io.sv ====
`timescale 1ns/1ps

// ==================================================
// Testbench for the paging and I/O port block
// ==================================================

module tb_spectrum_mem_io
	import zx_mem_pkg::*;
	import zx_io_pkg::*;
;

	localparam int          TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] LFSR_SEED      = 32'd67094;
	localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

	logic                  clk_sys;
	logic                  reset;
	model_t                model;
	logic [CPU_ADDR_W-1:0] addr;
	logic [DATA_W-1:0]     cpu_dout;
	logic                  mreq_n;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic                  m1_n;
	logic [DATA_W-1:0]     ram_dout;
	logic [KEY_W-1:0]      key_data;
	logic [JOY_W-1:0]      joystick;
	logic                  ear_in;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_rd;
	logic                  ram_we;
	logic [DATA_W-1:0]     cpu_din;
	logic                  screen_page;
	logic [2:0]            border_color;
	logic                  ear_out;
	logic                  mic_out;

	// Expected machine state, kept from the port rules
	model_t      exp_model;
	logic [7:0]  exp_7ffd;
	logic [7:0]  exp_1ffd;
	logic [2:0]  exp_border;
	logic        exp_ear;
	logic        exp_mic;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          cycle_count;

	spectrum_mem_io u_spectrum_mem_io (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.addr        (addr),
		.cpu_dout    (cpu_dout),
		.mreq_n      (mreq_n),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.m1_n        (m1_n),
		.ram_dout    (ram_dout),
		.key_data    (key_data),
		.joystick    (joystick),
		.ear_in      (ear_in),
		.ram_addr    (ram_addr),
		.ram_rd      (ram_rd),
		.ram_we      (ram_we),
		.cpu_din     (cpu_din),
		.screen_page (screen_page),
		.border_color(border_color),
		.ear_out     (ear_out),
		.mic_out     (mic_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Random bits, reference map and checking
	// ==================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ LFSR_TAPS;
		return next;
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
		end
	endtask

	// Bank seen in one 16 KiB region
	function automatic logic [BANK_W-1:0] ref_bank(input logic [1:0] region);
		logic [15:0] map_row;
		logic [3:0]  rom;
		if (exp_1ffd[0]) begin
			// Region 0 in the low nibble
			case (exp_1ffd[2:1])
				2'd0:    map_row = 16'h3210;
				2'd1:    map_row = 16'h7654;
				2'd2:    map_row = 16'h3654;
				default: map_row = 16'h3674;
			endcase
			return BANK_W'(map_row[{region, 2'b00} +: 4]);
		end
		if (exp_model == MODEL_PLUS3)
			rom = 4'd8 + (exp_1ffd[2] ? 4'd2 : 4'd0) + (exp_7ffd[4] ? 4'd1 : 4'd0);
		else
			rom = 4'd6 + ((exp_7ffd[4] || exp_model == MODEL_48K) ? 4'd1 : 4'd0);
		case (region)
			2'd0:    return BANK_W'(ROM_BANK_BASE + int'(rom));
			2'd1:    return BANK_W'(FIXED_BANK_1);
			2'd2:    return BANK_W'(FIXED_BANK_2);
			default: return BANK_W'(exp_7ffd[2:0]);
		endcase
	endfunction

	// ==================================================
	// Bus tasks
	// ==================================================

	task automatic reset_dut(input model_t m);
		@(posedge clk_sys);
		reset  <= 1'b1;
		model  <= m;
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		exp_model  = m;
		exp_7ffd   = 8'h00;
		exp_1ffd   = 8'h00;
		exp_border = 3'd0;
		exp_ear    = 1'b0;
		exp_mic    = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		logic locked;
		logic hit_7ffd;
		logic hit_1ffd;
		logic hit_fe;
		locked   = (exp_model == MODEL_48K) || exp_7ffd[5];
		hit_7ffd = !a[15] && !a[1] && (exp_model != MODEL_PLUS3 || a[14]) && !locked;
		hit_1ffd = (exp_model == MODEL_PLUS3) && (a[15:12] == 4'b0001) && !a[1] && !locked;
		hit_fe   = !a[0] || hit_7ffd;
		@(posedge clk_sys);
		addr     <= a;
		cpu_dout <= d;
		iorq_n   <= 1'b0;
		wr_n     <= 1'b0;
		repeat (3) @(posedge clk_sys);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		repeat (2) @(posedge clk_sys);
		if (hit_7ffd)
			exp_7ffd = d;
		if (hit_1ffd)
			exp_1ffd = d;
		if (hit_fe) begin
			exp_border = d[2:0];
			exp_ear    = d[4];
			exp_mic    = d[3];
		end
	endtask

	task automatic mem_access(input logic [15:0] a, input logic write);
		logic [31:0] r;
		logic [7:0]  rd_byte;
		logic        we_expected;
		rand_bits(8, r);
		rd_byte = r[7:0];
		// ROM region only in the normal map
		we_expected = write && !(!exp_1ffd[0] && a[15:14] == 2'd0);
		@(posedge clk_sys);
		addr     <= a;
		mreq_n   <= 1'b0;
		rd_n     <= write;
		wr_n     <= !write;
		ram_dout <= rd_byte;
		@(negedge clk_sys);
		check_value("ram_addr", 32'({ref_bank(a[15:14]), a[13:0]}), 32'(ram_addr));
		check_value("ram_rd", 32'(!write), 32'(ram_rd));
		check_value("ram_we", 32'(we_expected), 32'(ram_we));
		if (!write)
			check_value("cpu_din", 32'(rd_byte), 32'(cpu_din));
		@(posedge clk_sys);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic io_read(input logic [15:0] a, input logic [7:0] expected);
		@(posedge clk_sys);
		addr   <= a;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(negedge clk_sys);
		check_value("cpu_din", 32'(expected), 32'(cpu_din));
		@(posedge clk_sys);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	// Read and write once in every region
	task automatic check_map();
		logic [31:0] r;
		for (int region = 0; region < 4; region++) begin
			rand_bits(14, r);
			mem_access({2'(region), r[13:0]}, 1'b0);
			mem_access({2'(region), r[13:0]}, 1'b1);
		end
		check_value("screen_page", 32'(exp_7ffd[3]), 32'(screen_page));
	endtask

	task automatic check_ula();
		check_value("border_color", 32'(exp_border), 32'(border_color));
		check_value("ear_out", 32'(exp_ear), 32'(ear_out));
		check_value("mic_out", 32'(exp_mic), 32'(mic_out));
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_reset_map();
		reset_dut(MODEL_128K);
		check_map();
		reset_dut(MODEL_48K);
		check_map();
		reset_dut(MODEL_PLUS3);
		check_map();
	endtask

	task automatic test_paging_128k();
		logic [31:0] r;
		reset_dut(MODEL_128K);
		repeat (6) begin
			rand_bits(8, r);
			io_write(16'h7FFD, r[7:0] & 8'hDF);
			check_map();
		end
		// Lock bit, later writes must leave the map alone
		rand_bits(8, r);
		io_write(16'h7FFD, r[7:0] | 8'h20);
		check_map();
		repeat (3) begin
			rand_bits(8, r);
			io_write(16'h7FFD, r[7:0]);
			check_map();
		end
	endtask

	task automatic test_ignored_writes();
		logic [31:0] r;
		reset_dut(MODEL_48K);
		repeat (3) begin
			rand_bits(8, r);
			io_write(16'h7FFD, r[7:0]);
			check_map();
		end
		// 1FFD aliases 7FFD on the 128K, special mode stays off
		reset_dut(MODEL_128K);
		rand_bits(8, r);
		io_write(16'h1FFD, (r[7:0] & 8'hDF) | 8'h01);
		check_map();
	endtask

	task automatic test_plus3_maps();
		reset_dut(MODEL_PLUS3);
		for (int m = 0; m < 4; m++) begin
			io_write(16'h1FFD, {5'b00000, 2'(m), 1'b1});
			check_map();
		end
		for (int k = 0; k < 4; k++) begin
			io_write(16'h1FFD, {5'b00000, k[1], 2'b00});
			io_write(16'h7FFD, {3'b000, k[0], 1'b0, 3'(k)});
			check_map();
		end
	endtask

	task automatic test_ula_port();
		logic [31:0] r;
		reset_dut(MODEL_128K);
		check_ula();
		repeat (6) begin
			rand_bits(8, r);
			io_write(16'h00FE, r[7:0]);
			check_ula();
		end
	endtask

	task automatic test_reads();
		logic [31:0] key;
		logic [31:0] ear;
		logic [31:0] joy;
		logic [31:0] r;
		reset_dut(MODEL_128K);
		repeat (4) begin
			rand_bits(5, key);
			rand_bits(1, ear);
			rand_bits(6, joy);
			rand_bits(16, r);
			@(posedge clk_sys);
			key_data <= key[4:0];
			ear_in   <= ear[0];
			joystick <= joy[5:0];
			mem_access(r[15:0], 1'b0);
			io_read(16'h00FE, {1'b1, ear[0], 1'b1, key[4:0]});
			io_read(16'h001F, {2'b00, joy[5:0]});
			io_read(16'h00FF, FLOAT_BYTE);
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		reset    = 1'b1;
		model    = MODEL_128K;
		addr     = '0;
		cpu_dout = '0;
		mreq_n   = 1'b1;
		iorq_n   = 1'b1;
		rd_n     = 1'b1;
		wr_n     = 1'b1;
		m1_n     = 1'b1;
		ram_dout = '0;
		key_data = '1;
		joystick = '0;
		ear_in   = 1'b0;
		lfsr     = LFSR_SEED;
		errors   = 0;
		checks   = 0;

		test_reset_map();
		test_paging_128k();
		test_ignored_writes();
		test_plus3_maps();
		test_ula_port();
		test_reads();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/zx_mem_pkg.sv
logic/zx_io_pkg.sv
logic/io_decode.sv
logic/paging_regs.sv
logic/mem_map.sv
logic/ula_port.sv
logic/bus_read_mux.sv
logic/spectrum_mem_io.sv
bench/tb_spectrum_mem_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the result

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_spectrum_mem_io -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx '>>> PASS' sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
